/* all.f */
+incdir+.
sh_bus_pkg.sv
sh_ctl_pkg.sv
sh_prescaler.sv
sh_wdt.sv
sh_intc.sv
sh_ram.sv
sh_periph_top.sv
tb_sh_periph.sv

/* sh_bus_pkg.sv */
package sh_bus_pkg;

	// Decoded view of a bus address
	typedef struct packed {
		logic [3:0]  area;
		logic [11:0] pad;
		logic [3:0]  block;
		logic [5:0]  reg_idx;
		logic [1:0]  lane;
	} bus_addr_f_t;

	// Same 28-bit word, raw or split into fields
	typedef union packed {
		logic [27:0] raw;
		bus_addr_f_t fld;
	} bus_addr_u;

	// One request from the bus master, req is a single-cycle strobe
	typedef struct packed {
		logic        req;
		logic        we;
		logic [3:0]  be;
		bus_addr_u   addr;
		logic [31:0] wdata;
	} bus_req_t;

	// Read response of one slave
	typedef struct packed {
		logic        act;
		logic [31:0] rdata;
	} slave_rsp_t;

endpackage

/* sh_ctl_pkg.sv */
package sh_ctl_pkg;

	typedef logic [3:0] int_lvl_t;
	typedef logic [7:0] int_vec_t;

	// Interrupt request presented to the CPU side
	typedef struct packed {
		logic     req;
		int_lvl_t lvl;
		int_vec_t vec;
	} int_out_t;

	// One-cycle strobes from the prescaler
	typedef struct packed {
		logic div2;
		logic div64;
		logic div128;
		logic div256;
		logic div512;
		logic div1024;
		logic div4096;
		logic div8192;
	} presc_tap_t;

endpackage

/* sh_intc.sv */
`include "sh_periph_consts.svh"

module sh_intc
	import sh_bus_pkg::*;
	import sh_ctl_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  bus_req_t   bus,
	output slave_rsp_t rsp,
	input  logic       nmi_n,
	input  logic [3:0] irq_n,
	input  logic       iti,
	input  int_lvl_t   int_mask,
	input  logic       int_ack,
	output int_out_t   int_out
);

	// Source 0 is NMI, 1 to 4 are IRQ0 to IRQ3, 5 is ITI
	localparam int NSRC = 6;

	logic             sel;
	logic             nmi_q;
	logic             nmi_qq;
	logic [3:0]       irq_q;
	logic [3:0]       irq_qq;
	logic [4:0]       fall;
	logic [4:0]       pend;
	logic [4:0]       clr;
	logic [15:0]      ipra;
	int_lvl_t         iprb;
	int_lvl_t         src_lvl [NSRC];
	int_vec_t         src_vec [NSRC];
	logic [NSRC-1:0]  elig;
	logic             found;
	logic [2:0]       win;
	int_lvl_t         win_lvl;
	logic [2:0]       cur_src;
	logic             act_r;
	logic [31:0]      rdata_r;

	assign sel = bus.req && bus.addr.fld.area == `SH_AREA_PERIPH &&
		bus.addr.fld.block == `SH_BLK_INTC;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ipra <= '0;
			iprb <= '0;
		end else if (sel && bus.we) begin
			case (bus.addr.fld.reg_idx)
				`SH_REG_IPRA: ipra <= bus.wdata[15:0];
				`SH_REG_IPRB: iprb <= bus.wdata[3:0];
				default: ;
			endcase
		end
	end

	// Pin sampling and falling edge detect
	assign fall = {irq_qq & ~irq_q, nmi_qq & ~nmi_q};
	assign clr  = (int_ack && int_out.req && cur_src < 3'd5) ? 5'(5'b1 << cur_src) : '0;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			nmi_q  <= 1'b1;
			nmi_qq <= 1'b1;
			irq_q  <= '1;
			irq_qq <= '1;
			pend   <= '0;
		end else begin
			nmi_q  <= nmi_n;
			nmi_qq <= nmi_q;
			irq_q  <= irq_n;
			irq_qq <= irq_q;
			// A new edge wins over an acknowledge in the same cycle
			pend   <= (pend & ~clr) | fall;
		end
	end

	always_comb begin
		src_lvl[0] = `SH_LVL_NMI;
		src_vec[0] = `SH_VEC_NMI;
		elig[0]    = pend[0];
		for (int k = 0; k < 4; k++) begin
			src_lvl[k+1] = ipra[4*k +: 4];
			src_vec[k+1] = `SH_VEC_IRQ0 + 8'(k);
			elig[k+1]    = pend[k+1] && src_lvl[k+1] > int_mask;
		end
		src_lvl[5] = iprb;
		src_vec[5] = `SH_VEC_ITI;
		elig[5]    = iti && iprb > int_mask;
	end

	// Highest level wins, ties keep the lower source index
	always_comb begin
		found   = 1'b0;
		win     = '0;
		win_lvl = '0;
		for (int i = 0; i < NSRC; i++) begin
			if (elig[i] && (!found || src_lvl[i] > win_lvl)) begin
				found   = 1'b1;
				win     = 3'(i);
				win_lvl = src_lvl[i];
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			int_out <= '0;
			cur_src <= '0;
		end else begin
			int_out.req <= found;
			int_out.lvl <= found ? win_lvl : '0;
			int_out.vec <= found ? src_vec[win] : '0;
			cur_src     <= win;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			act_r <= 1'b0;
		end else begin
			act_r <= sel && !bus.we;
		end
	end

	always_ff @(posedge CLK) begin
		if (sel && !bus.we) begin
			case (bus.addr.fld.reg_idx)
				`SH_REG_IPRA: rdata_r <= {16'd0, ipra};
				`SH_REG_IPRB: rdata_r <= {28'd0, iprb};
				default:      rdata_r <= '0;
			endcase
		end
	end

	assign rsp.act   = act_r;
	assign rsp.rdata = rdata_r;

	// Output is registered, so compare against last cycle's mask
	a_lvl_above_mask: assert property (
		@(posedge CLK) disable iff (!RST_N)
		int_out.req && int_out.vec != `SH_VEC_NMI |-> int_out.lvl > $past(int_mask)
	);

endmodule

/* sh_periph_consts.svh */
`ifndef SH_PERIPH_CONSTS_SVH
`define SH_PERIPH_CONSTS_SVH

// Address areas
`define SH_AREA_RAM        4'hE
`define SH_AREA_PERIPH     4'hF

// Peripheral blocks inside the peripheral area
`define SH_BLK_INTC        4'd0
`define SH_BLK_WDT         4'd1

// Interrupt controller register indexes
`define SH_REG_IPRA        6'd0
`define SH_REG_IPRB        6'd1

// Timer register indexes
`define SH_REG_TCSR        6'd0
`define SH_REG_TCNT        6'd1

// Write keys, carried in wdata[15:8]
`define SH_KEY_TCSR        8'hA5
`define SH_KEY_TCNT        8'h5A

// Vector numbers, IRQ0 to IRQ3 are consecutive
`define SH_VEC_NMI         8'd11
`define SH_VEC_IRQ0        8'd64
`define SH_VEC_ITI         8'd120

`define SH_LVL_NMI         4'd15

// Length of the watchdog overflow pulse in cycles
`define SH_WDT_OVF_CYCLES  16

`define SH_RAM_WORDS       64

`endif

/* sh_periph_top.sv */
module sh_periph_top
	import sh_bus_pkg::*;
	import sh_ctl_pkg::*;
(
	input  logic        CLK,
	input  logic        RST_N,
	input  bus_req_t    bus,
	output logic [31:0] rdata,
	input  logic        nmi_n,
	input  logic [3:0]  irq_n,
	input  int_lvl_t    int_mask,
	input  logic        int_ack,
	output int_out_t    int_out,
	output logic        wdtovf_n
);

	presc_tap_t taps;
	slave_rsp_t ram_rsp;
	slave_rsp_t intc_rsp;
	slave_rsp_t wdt_rsp;
	logic       iti;

	sh_prescaler presc (
		.CLK   (CLK),
		.RST_N (RST_N),
		.taps  (taps)
	);

	sh_ram ram (
		.CLK   (CLK),
		.RST_N (RST_N),
		.bus   (bus),
		.rsp   (ram_rsp)
	);

	sh_wdt wdt (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.bus      (bus),
		.taps     (taps),
		.rsp      (wdt_rsp),
		.iti      (iti),
		.wdtovf_n (wdtovf_n)
	);

	sh_intc intc (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.bus      (bus),
		.rsp      (intc_rsp),
		.nmi_n    (nmi_n),
		.irq_n    (irq_n),
		.iti      (iti),
		.int_mask (int_mask),
		.int_ack  (int_ack),
		.int_out  (int_out)
	);

	// Read data by priority of the answering block
	always_comb begin
		if (intc_rsp.act) begin
			rdata = intc_rsp.rdata;
		end else if (wdt_rsp.act) begin
			rdata = wdt_rsp.rdata;
		end else if (ram_rsp.act) begin
			rdata = ram_rsp.rdata;
		end else begin
			rdata = '0;
		end
	end

endmodule

/* sh_prescaler.sv */
module sh_prescaler
	import sh_ctl_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	output presc_tap_t taps
);

	logic [12:0] cnt;

	// Free-running divider, a tap fires when its low bits are all ones
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cnt  <= '0;
			taps <= '0;
		end else begin
			cnt          <= cnt + 13'd1;
			taps.div2    <= cnt[0];
			taps.div64   <= &cnt[5:0];
			taps.div128  <= &cnt[6:0];
			taps.div256  <= &cnt[7:0];
			taps.div512  <= &cnt[8:0];
			taps.div1024 <= &cnt[9:0];
			taps.div4096 <= &cnt[11:0];
			taps.div8192 <= &cnt[12:0];
		end
	end

endmodule

/* sh_ram.sv */
`include "sh_periph_consts.svh"

module sh_ram
	import sh_bus_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  bus_req_t   bus,
	output slave_rsp_t rsp
);

	logic        sel;
	logic [5:0]  idx;
	logic [31:0] mem [`SH_RAM_WORDS];
	logic        act_r;
	logic [31:0] rdata_r;

	assign sel = bus.req && bus.addr.fld.area == `SH_AREA_RAM;
	// Upper address bits are not decoded, so the array aliases
	assign idx = bus.addr.fld.reg_idx;

	always_ff @(posedge CLK) begin
		if (sel && bus.we) begin
			for (int b = 0; b < 4; b++) begin
				if (bus.be[b]) begin
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
		if (sel && !bus.we) begin
			rdata_r <= mem[idx];
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			act_r <= 1'b0;
		end else begin
			act_r <= sel && !bus.we;
		end
	end

	assign rsp.act   = act_r;
	assign rsp.rdata = rdata_r;

	a_act_after_req: assert property (
		@(posedge CLK) disable iff (!RST_N) rsp.act |-> $past(bus.req)
	);

endmodule

/* sh_wdt.sv */
`include "sh_periph_consts.svh"

module sh_wdt
	import sh_bus_pkg::*;
	import sh_ctl_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_N,
	input  bus_req_t   bus,
	input  presc_tap_t taps,
	output slave_rsp_t rsp,
	output logic       iti,
	output logic       wdtovf_n
);

	localparam int OVF_W = $clog2(`SH_WDT_OVF_CYCLES + 1);

	logic             sel;
	logic             tcsr_wr;
	logic             tcnt_wr;
	logic [7:0]       tcsr;
	logic [7:0]       tcnt;
	logic [7:0]       tcsr_d;
	logic [7:0]       tcnt_d;
	logic [7:0]       tap_vec;
	logic             tick;
	logic             wrap;
	logic [OVF_W-1:0] ovf_cnt;
	logic             act_r;
	logic [31:0]      rdata_r;

	assign sel = bus.req && bus.addr.fld.area == `SH_AREA_PERIPH &&
		bus.addr.fld.block == `SH_BLK_WDT;
	assign tcsr_wr = sel && bus.we && bus.addr.fld.reg_idx == `SH_REG_TCSR &&
		bus.wdata[15:8] == `SH_KEY_TCSR;
	assign tcnt_wr = sel && bus.we && bus.addr.fld.reg_idx == `SH_REG_TCNT &&
		bus.wdata[15:8] == `SH_KEY_TCNT;

	// Clock select 0 to 7 picks div2 through div8192
	assign tap_vec = {taps.div8192, taps.div4096, taps.div1024, taps.div512,
		taps.div256, taps.div128, taps.div64, taps.div2};
	assign tick = tcsr[5] && tap_vec[tcsr[2:0]];
	assign wrap = tick && tcnt == 8'hFF && !tcnt_wr;

	always_comb begin
		tcnt_d = tcnt;
		if (tcnt_wr) begin
			tcnt_d = bus.wdata[7:0];
		end else if (tick) begin
			tcnt_d = tcnt + 8'd1;
		end

		tcsr_d = tcsr;
		if (tcsr_wr) begin
			tcsr_d = bus.wdata[7:0];
		end else if (wrap) begin
			tcsr_d[7] = 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tcsr <= '0;
			tcnt <= '0;
		end else begin
			tcsr <= tcsr_d;
			tcnt <= tcnt_d;
		end
	end

	// Overflow pulse in watchdog mode, released at once in interval mode
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wdtovf_n <= 1'b1;
			ovf_cnt  <= '0;
		end else if (wrap && tcsr_d[6]) begin
			wdtovf_n <= 1'b0;
			ovf_cnt  <= OVF_W'(`SH_WDT_OVF_CYCLES - 1);
		end else if (!tcsr_d[6]) begin
			wdtovf_n <= 1'b1;
			ovf_cnt  <= '0;
		end else if (ovf_cnt != '0) begin
			ovf_cnt <= ovf_cnt - 1'b1;
		end else begin
			wdtovf_n <= 1'b1;
		end
	end

	assign iti = tcsr[7] && !tcsr[6];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			act_r <= 1'b0;
		end else begin
			act_r <= sel && !bus.we;
		end
	end

	always_ff @(posedge CLK) begin
		if (sel && !bus.we) begin
			case (bus.addr.fld.reg_idx)
				`SH_REG_TCSR: rdata_r <= {24'd0, tcsr};
				`SH_REG_TCNT: rdata_r <= {24'd0, tcnt};
				default:      rdata_r <= '0;
			endcase
		end
	end

	assign rsp.act   = act_r;
	assign rsp.rdata = rdata_r;

	a_no_ovf_in_interval: assert property (
		@(posedge CLK) disable iff (!RST_N) !tcsr[6] |-> wdtovf_n
	);

endmodule

/* tb_sh_periph.sv */
`include "sh_periph_consts.svh"

module tb_sh_periph
	import sh_bus_pkg::*;
	import sh_ctl_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TMO = 400;

	logic        CLK;
	logic        RST_N;
	bus_req_t    bus;
	logic [31:0] rdata;
	logic        nmi_n;
	logic [3:0]  irq_n;
	int_lvl_t    int_mask;
	logic        int_ack;
	int_out_t    int_out;
	logic        wdtovf_n;

	int          errors;
	int          timeouts;
	logic [31:0] ram_model [`SH_RAM_WORDS];
	logic [3:0]  pend_model;
	logic [15:0] ipra_val;

	sh_periph_top dut0 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.bus      (bus),
		.rdata    (rdata),
		.nmi_n    (nmi_n),
		.irq_n    (irq_n),
		.int_mask (int_mask),
		.int_ack  (int_ack),
		.int_out  (int_out),
		.wdtovf_n (wdtovf_n)
	);

	always #2 CLK = ~CLK;

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t ns: %s", $time, what);
	endtask

	// Pad and lane are random, the slaves must ignore them
	function automatic logic [27:0] addr_of(input logic [3:0] area, input logic [3:0] blk,
		input logic [5:0] idx);
		bus_addr_u a;
		a.raw = 28'($urandom);
		a.fld.area = area;
		a.fld.block = blk;
		a.fld.reg_idx = idx;
		return a.raw;
	endfunction

	task automatic bus_write(input logic [27:0] addr, input logic [3:0] be, input logic [31:0] wd);
		bus = {1'b1, 1'b1, be, addr, wd};
		next_cycle();
		bus = '0;
	endtask

	task automatic bus_read(input logic [27:0] addr, output logic [31:0] data);
		bus = {1'b1, 1'b0, 4'hF, addr, 32'd0};
		next_cycle();
		bus = '0;
		data = rdata;
	endtask

	task automatic wait_int_req(input string what);
		int n;
		n = 0;
		while (!int_out.req && n < TMO) begin
			next_cycle();
			n++;
		end
		if (!int_out.req) report_timeout(what);
	endtask

	task automatic ack_int();
		int_ack = 1'b1;
		next_cycle();
		int_ack = 1'b0;
		next_cycle();
	endtask

	// Highest level above the mask, ties to the lower IRQ number
	function automatic int irq_winner(input logic [3:0] pend, input logic [15:0] ipra,
		input int_lvl_t mask);
		int win;
		win = -1;
		for (int k = 0; k < 4; k++) begin
			if (pend[k] && ipra[4*k +: 4] > mask &&
				(win < 0 || ipra[4*k +: 4] > ipra[4*win +: 4])) win = k;
		end
		return win;
	endfunction

	initial begin
		logic [31:0] d;
		logic [31:0] v;
		logic [3:0]  be;
		logic [3:0]  sub;
		logic [7:0]  key;
		logic [7:0]  tcsr_m;
		logic [7:0]  tcnt_m;
		int_lvl_t    lvl;
		int          idx;
		int          win;
		int          n;

		void'($urandom(3635));
		CLK = 1'b0;
		RST_N = 1'b0;
		bus = '0;
		nmi_n = 1'b1;
		irq_n = '1;
		int_mask = '0;
		int_ack = 1'b0;
		errors = 0;
		timeouts = 0;
		pend_model = '0;
		tcsr_m = '0;
		tcnt_m = '0;
		repeat (3) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		next_cycle();

		// RAM fill, then mixed byte-lane writes and reads through aliases
		for (int i = 0; i < `SH_RAM_WORDS; i++) begin
			ram_model[i] = $urandom;
			bus_write(addr_of(`SH_AREA_RAM, 4'($urandom), 6'(i)), 4'hF, ram_model[i]);
		end
		repeat (150) begin
			idx = $urandom_range(`SH_RAM_WORDS - 1);
			if ($urandom_range(1) == 1) begin
				be = 4'($urandom);
				d = $urandom;
				for (int b = 0; b < 4; b++) begin
					if (be[b]) ram_model[idx][8*b +: 8] = d[8*b +: 8];
				end
				bus_write(addr_of(`SH_AREA_RAM, 4'($urandom), 6'(idx)), be, d);
			end else begin
				bus_read(addr_of(`SH_AREA_RAM, 4'($urandom), 6'(idx)), v);
				check_value(v, ram_model[idx], "RAM read");
			end
		end

		repeat (20) begin
			bus_read(addr_of(4'($urandom_range(13)), 4'($urandom), 6'($urandom)), v);
			check_value(v, 32'd0, "unmapped area read");
			bus_read(addr_of(`SH_AREA_PERIPH, 4'($urandom_range(15, 2)), 6'($urandom)), v);
			check_value(v, 32'd0, "unmapped block read");
		end
		repeat (8) begin
			d = $urandom;
			bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRA), 4'hF, d);
			bus_read(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRA), v);
			check_value(v, {16'd0, d[15:0]}, "IPRA readback");
			bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRB), 4'hF, d);
			bus_read(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRB), v);
			check_value(v, {28'd0, d[3:0]}, "IPRB readback");
		end

		// Timer registers with wrong and right keys, TME and OVF kept clear
		repeat (8) begin
			key = 8'($urandom);
			if (key == `SH_KEY_TCSR) key = 8'h00;
			bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), 4'($urandom),
				{16'($urandom), key, 8'($urandom)});
			key = 8'($urandom);
			if (key == `SH_KEY_TCNT) key = 8'h00;
			bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCNT), 4'($urandom),
				{16'($urandom), key, 8'($urandom)});
			bus_read(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), v);
			check_value(v, {24'd0, tcsr_m}, "TCSR after wrong key");
			bus_read(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCNT), v);
			check_value(v, {24'd0, tcnt_m}, "TCNT after wrong key");
			tcsr_m = 8'($urandom) & 8'h5F;
			tcnt_m = 8'($urandom);
			bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), 4'($urandom),
				{16'($urandom), `SH_KEY_TCSR, tcsr_m});
			bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCNT), 4'($urandom),
				{16'($urandom), `SH_KEY_TCNT, tcnt_m});
			bus_read(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), v);
			check_value(v, {24'd0, tcsr_m}, "TCSR keyed write");
			bus_read(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCNT), v);
			check_value(v, {24'd0, tcnt_m}, "TCNT keyed write");
		end

		// Interval mode overflow raises ITI
		lvl = 4'($urandom_range(15, 1));
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRA), 4'hF, 32'd0);
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRB), 4'hF, {28'd0, lvl});
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCNT), 4'hF,
			{16'd0, `SH_KEY_TCNT, 8'hF0});
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), 4'hF,
			{16'd0, `SH_KEY_TCSR, 8'h20});
		wait_int_req("no ITI request after interval overflow");
		check_value(int_out.vec, `SH_VEC_ITI, "ITI vector");
		check_value(int_out.lvl, lvl, "ITI level");
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), 4'hF,
			{16'd0, `SH_KEY_TCSR, 8'h00});
		n = 0;
		while (int_out.req && n < TMO) begin
			next_cycle();
			n++;
		end
		if (int_out.req) report_timeout("ITI request stayed high after OVF was cleared");

		// IRQ edges against the arbitration model
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRB), 4'hF, 32'd0);
		repeat (10) begin
			int_mask = 4'($urandom);
			ipra_val = 16'($urandom);
			bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRA), 4'hF, {16'd0, ipra_val});
			irq_n = '1;
			repeat (2) next_cycle();
			sub = 4'($urandom);
			irq_n = ~sub;
			pend_model = pend_model | sub;
			// Input register, pending latch, then the output register
			repeat (3) next_cycle();
			win = irq_winner(pend_model, ipra_val, int_mask);
			while (win >= 0) begin
				wait_int_req("no IRQ request for a pending source");
				check_value(int_out.lvl, ipra_val[4*win +: 4], "IRQ level");
				check_value(int_out.vec, `SH_VEC_IRQ0 + win, "IRQ vector");
				ack_int();
				pend_model[win] = 1'b0;
				win = irq_winner(pend_model, ipra_val, int_mask);
			end
			check_value(int_out.req, 1'b0, "request with no eligible source");
		end

		int_mask = 4'hF;
		nmi_n = 1'b0;
		wait_int_req("no request after NMI edge");
		check_value(int_out.vec, `SH_VEC_NMI, "NMI vector");
		check_value(int_out.lvl, `SH_LVL_NMI, "NMI level");
		ack_int();
		check_value(int_out.req, 1'b0, "request after NMI acknowledge");
		nmi_n = 1'b1;
		irq_n = '1;

		// Watchdog mode, level-0 IRQs keep old pending latches quiet
		int_mask = '0;
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRA), 4'hF, 32'd0);
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_INTC, `SH_REG_IPRB), 4'hF, {28'd0, lvl});
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCNT), 4'hF,
			{16'd0, `SH_KEY_TCNT, 8'hF0});
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), 4'hF,
			{16'd0, `SH_KEY_TCSR, 8'h60});
		n = 0;
		while (wdtovf_n && n < TMO) begin
			check_value(int_out.req, 1'b0, "request in watchdog mode");
			next_cycle();
			n++;
		end
		if (wdtovf_n) begin
			report_timeout("wdtovf_n never went low in watchdog mode");
		end else begin
			n = 0;
			while (!wdtovf_n && n < 4 * `SH_WDT_OVF_CYCLES) begin
				check_value(int_out.req, 1'b0, "request during watchdog pulse");
				next_cycle();
				n++;
			end
			check_value(n, `SH_WDT_OVF_CYCLES, "watchdog pulse length");
		end
		bus_write(addr_of(`SH_AREA_PERIPH, `SH_BLK_WDT, `SH_REG_TCSR), 4'hF,
			{16'd0, `SH_KEY_TCSR, 8'h00});
		next_cycle();

		$display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
